//--- design/rs5_mem_pkg.sv
// Memory subsystem shared definitions

package rs5_mem_pkg;

    ////////////////////////////////////////////////////////////
    // Memory geometry
    ////////////////////////////////////////////////////////////

    localparam int MEM_BYTES  = 1024;                // RAM size in bytes
    localparam int ADDR_W     = $clog2(MEM_BYTES);   // Byte address width
    localparam int WORD_BYTES = 4;                   // RV32 word
    localparam int LANE_W     = $clog2(WORD_BYTES);  // Byte lane select bits
    localparam int RAM_PORTS  = 2;                   // Port A and port B

    // Hex image, one byte per line, loaded at time zero
    localparam string IMAGE_FILE = "dv/mem_image.hex";

    ////////////////////////////////////////////////////////////
    // Data types
    ////////////////////////////////////////////////////////////

    typedef logic [8*WORD_BYTES-1:0] word_t;   // Data word
    typedef logic [ADDR_W-1:0]       addr_t;   // Byte address
    typedef logic [WORD_BYTES-1:0]   be_t;     // Bit n enables lane n

    // Load and store operations, RISC-V naming
    typedef enum logic [2:0] {
        OP_LB,      // Load byte, sign extended
        OP_LH,      // Load half, sign extended
        OP_LW,      // Load word
        OP_LBU,     // Load byte, zero extended
        OP_LHU,     // Load half, zero extended
        OP_SB,      // Store byte
        OP_SH,      // Store half
        OP_SW       // Store word
    } mem_op_e;

    // Byte and half accesses in the low lanes
    localparam be_t BE_BYTE = be_t'(4'b0001);
    localparam be_t BE_HALF = be_t'(4'b0011);
    localparam be_t BE_WORD = be_t'(4'b1111);

endpackage

//--- design/ram_mem.sv
// Dual-port byte-enabled RAM

module ram_mem
    import rs5_mem_pkg::*;
(
    input  logic  clk,

    // Port A
    input  logic  en_a_i,
    input  be_t   be_a_i,
    input  addr_t addr_a_i,
    input  word_t wdata_a_i,
    output word_t rdata_a_o,

    // Port B
    input  logic  en_b_i,
    input  be_t   be_b_i,
    input  addr_t addr_b_i,
    input  word_t wdata_b_i,
    output word_t rdata_b_o
);

    ////////////////////////////////////////////////////////////
    // Storage
    ////////////////////////////////////////////////////////////

    logic [7:0] mem [MEM_BYTES];   // Byte array, no reset

    // Image load before the first edge
    initial begin
        $readmemh(IMAGE_FILE, mem);
    end

    ////////////////////////////////////////////////////////////
    // Port bundling
    ////////////////////////////////////////////////////////////

    // Both ports share one write and one read description
    logic  en_p    [RAM_PORTS];
    be_t   be_p    [RAM_PORTS];
    addr_t addr_p  [RAM_PORTS];
    word_t wdata_p [RAM_PORTS];
    word_t rdata_p [RAM_PORTS];

    assign en_p[0]    = en_a_i;
    assign be_p[0]    = be_a_i;
    assign addr_p[0]  = addr_a_i;
    assign wdata_p[0] = wdata_a_i;

    assign en_p[1]    = en_b_i;
    assign be_p[1]    = be_b_i;
    assign addr_p[1]  = addr_b_i;
    assign wdata_p[1] = wdata_b_i;

    assign rdata_a_o  = rdata_p[0];
    assign rdata_b_o  = rdata_p[1];

    ////////////////////////////////////////////////////////////
    // Writes
    ////////////////////////////////////////////////////////////

    // Same byte from both ports in one cycle is undefined
    always @(posedge clk) begin
        for (int p = 0; p < RAM_PORTS; p++) begin
            if (en_p[p] && (be_p[p] != '0)) begin      // Non-zero mask means store
                for (int b = 0; b < WORD_BYTES; b++) begin
                    if (be_p[p][b]) begin
                        // Little-endian, lane b lands at addr+b
                        mem[addr_t'(addr_p[p] + b)] <= wdata_p[p][8*b +: 8];
                    end
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Reads
    ////////////////////////////////////////////////////////////

    for (genvar p = 0; p < RAM_PORTS; p++) begin : g_rd_port
        always_ff @(posedge clk) begin
            if (!en_p[p]) begin
                rdata_p[p] <= '0;                      // Idle port reads as zero
            end
            else if (be_p[p] == '0) begin
                // Old data if the other port writes the same bytes
                for (int b = 0; b < WORD_BYTES; b++) begin
                    rdata_p[p][8*b +: 8] <= mem[addr_t'(addr_p[p] + b)];
                end
            end
            // A write leaves the output as it was
        end
    end

endmodule

//--- design/lsu_align.sv
// Load/store alignment unit

module lsu_align
    import rs5_mem_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n_i,

    // Master side
    input  logic    en_i,          // Access strobe
    input  mem_op_e op_i,
    input  addr_t   addr_i,        // Byte address
    input  word_t   wdata_i,       // Store data, right aligned
    output word_t   rdata_o,       // Extended load result
    output logic    err_o,         // Misaligned request, one cycle late

    // RAM side
    output logic    mem_en_o,
    output be_t     mem_be_o,
    output addr_t   mem_addr_o,    // Word aligned
    output word_t   mem_wdata_o,   // Lane shifted
    input  word_t   mem_rdata_i    // Raw word, one cycle after request
);

    ////////////////////////////////////////////////////////////
    // Request decode
    ////////////////////////////////////////////////////////////

    logic [LANE_W-1:0] lane;       // Low address bits
    logic              is_store;
    logic              misaligned;
    be_t               width_be;   // Mask before the lane shift

    assign lane = addr_i[LANE_W-1:0];

    always_comb begin
        is_store   = 1'b0;
        misaligned = 1'b0;
        width_be   = '0;
        unique case (op_i)
            OP_LW: begin
                misaligned = (lane != '0);
            end
            OP_LH, OP_LHU: begin
                misaligned = lane[0];
            end
            OP_LB, OP_LBU: begin
                misaligned = 1'b0;                  // Bytes never misalign
            end
            OP_SW: begin
                is_store   = 1'b1;
                misaligned = (lane != '0);
                width_be   = BE_WORD;
            end
            OP_SH: begin
                is_store   = 1'b1;
                misaligned = lane[0];
                width_be   = BE_HALF;
            end
            OP_SB: begin
                is_store   = 1'b1;
                width_be   = BE_BYTE;
            end
            default: begin
                misaligned = 1'b0;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////
    // RAM request
    ////////////////////////////////////////////////////////////

    assign mem_en_o    = en_i && !misaligned;          // Misaligned never reaches RAM
    assign mem_be_o    = is_store ? be_t'(width_be << lane) : '0;   // Zero mask for loads
    assign mem_addr_o  = {addr_i[ADDR_W-1:LANE_W], {LANE_W{1'b0}}};
    assign mem_wdata_o = wdata_i << {lane, 3'b000};    // Into the byte lane

    ////////////////////////////////////////////////////////////
    // Response tracking
    ////////////////////////////////////////////////////////////

    mem_op_e           op_q;
    logic [LANE_W-1:0] lane_q;
    logic              load_q;     // Aligned load in flight
    logic              err_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            op_q   <= OP_LW;
            lane_q <= '0;
            load_q <= 1'b0;
            err_q  <= 1'b0;
        end
        else begin
            op_q   <= op_i;
            lane_q <= lane;
            load_q <= en_i && !misaligned && !is_store;
            err_q  <= en_i && misaligned;           // High for exactly one cycle
        end
    end

    assign err_o = err_q;

    ////////////////////////////////////////////////////////////
    // Load extraction
    ////////////////////////////////////////////////////////////

    word_t shifted;                // Addressed byte moved to lane 0

    assign shifted = mem_rdata_i >> {lane_q, 3'b000};

    always_comb begin
        rdata_o = '0;                                  // Stores and idle read zero
        if (load_q) begin
            unique case (op_q)
                OP_LB:   rdata_o = {{24{shifted[7]}}, shifted[7:0]};
                OP_LBU:  rdata_o = {24'h0, shifted[7:0]};
                OP_LH:   rdata_o = {{16{shifted[15]}}, shifted[15:0]};
                OP_LHU:  rdata_o = {16'h0, shifted[15:0]};
                OP_LW:   rdata_o = mem_rdata_i;        // Lane is always 0 here
                default: rdata_o = '0;
            endcase
        end
    end

endmodule

//--- design/mem_subsystem.sv
// Dual-master memory subsystem top

module mem_subsystem
    import rs5_mem_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n_i,

    // Master A, core data side
    input  logic    en_a_i,
    input  mem_op_e op_a_i,
    input  addr_t   addr_a_i,
    input  word_t   wdata_a_i,
    output word_t   rdata_a_o,
    output logic    err_a_o,

    // Master B, loader or debug
    input  logic    en_b_i,
    input  mem_op_e op_b_i,
    input  addr_t   addr_b_i,
    input  word_t   wdata_b_i,
    output word_t   rdata_b_o,
    output logic    err_b_o
);

    ////////////////////////////////////////////////////////////
    // RAM port nets
    ////////////////////////////////////////////////////////////

    logic  ram_en_a,    ram_en_b;
    be_t   ram_be_a,    ram_be_b;
    addr_t ram_addr_a,  ram_addr_b;
    word_t ram_wdata_a, ram_wdata_b;
    word_t ram_rdata_a, ram_rdata_b;

    // Port A alignment
    lsu_align u_lsu_a (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .en_i        (en_a_i),
        .op_i        (op_a_i),
        .addr_i      (addr_a_i),
        .wdata_i     (wdata_a_i),
        .rdata_o     (rdata_a_o),
        .err_o       (err_a_o),
        .mem_en_o    (ram_en_a),
        .mem_be_o    (ram_be_a),
        .mem_addr_o  (ram_addr_a),
        .mem_wdata_o (ram_wdata_a),
        .mem_rdata_i (ram_rdata_a)
    );

    // Port B alignment
    lsu_align u_lsu_b (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .en_i        (en_b_i),
        .op_i        (op_b_i),
        .addr_i      (addr_b_i),
        .wdata_i     (wdata_b_i),
        .rdata_o     (rdata_b_o),
        .err_o       (err_b_o),
        .mem_en_o    (ram_en_b),
        .mem_be_o    (ram_be_b),
        .mem_addr_o  (ram_addr_b),
        .mem_wdata_o (ram_wdata_b),
        .mem_rdata_i (ram_rdata_b)
    );

    // Shared storage, no arbitration
    ram_mem u_ram (
        .clk       (clk),
        .en_a_i    (ram_en_a),
        .be_a_i    (ram_be_a),
        .addr_a_i  (ram_addr_a),
        .wdata_a_i (ram_wdata_a),
        .rdata_a_o (ram_rdata_a),
        .en_b_i    (ram_en_b),
        .be_b_i    (ram_be_b),
        .addr_b_i  (ram_addr_b),
        .wdata_b_i (ram_wdata_b),
        .rdata_b_o (ram_rdata_b)
    );

endmodule

//--- dv/tb_mem_subsystem.sv
// Memory subsystem testbench

module tb_mem_subsystem
    import rs5_mem_pkg::*;
();

    ////////////////////////////////////////////////////////////
    // Signals and vector storage
    ////////////////////////////////////////////////////////////

    localparam string VEC_FILE      = "dv/mem_test_input.txt";
    localparam int    RESET_CYCLES  = 5;
    localparam int    RESET_TIMEOUT = 50;        // Cycles allowed for reset release

    logic    clk = 1'b0;
    logic    rst_n_i;
    logic    en_a, en_b;
    mem_op_e op_a, op_b;
    addr_t   addr_a, addr_b;
    word_t   wdata_a, wdata_b;
    word_t   rdata_a, rdata_b;
    logic    err_a, err_b;

    word_t   exp_rdata_a, exp_rdata_b;           // Expected one cycle later
    logic    exp_err_a, exp_err_b;
    int      cur_line;                           // Vector line being checked

    // One entry per vector line
    logic    vec_port_b [$];                     // 0 means port A
    logic    vec_join   [$];                     // Same cycle as the line before
    logic    vec_en     [$];
    mem_op_e vec_op     [$];
    addr_t   vec_addr   [$];
    word_t   vec_wdata  [$];
    word_t   vec_rdata  [$];
    logic    vec_err    [$];
    int      vec_line   [$];

    mem_subsystem u_mem_subsystem (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .en_a_i    (en_a),
        .op_a_i    (op_a),
        .addr_a_i  (addr_a),
        .wdata_a_i (wdata_a),
        .rdata_a_o (rdata_a),
        .err_a_o   (err_a),
        .en_b_i    (en_b),
        .op_b_i    (op_b),
        .addr_b_i  (addr_b),
        .wdata_b_i (wdata_b),
        .rdata_b_o (rdata_b),
        .err_b_o   (err_b)
    );

    always #10 clk = ~clk;                       // 20 unit period

    // Reset low for five cycles, released on a falling edge
    initial begin
        rst_n_i = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n_i = 1'b1;
    end

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Some tests failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            abort_run($sformatf("FAIL %s: got 0x%08h expected 0x%08h (vector line %0d)",
                                name, got, exp, cur_line));
        end
    endtask

    task automatic check_err(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("FAIL %s: got 0x%0h expected 0x%0h (vector line %0d)",
                                name, got, exp, cur_line));
        end
    endtask

    // Both ports every cycle, an idle port must read zero
    task automatic check_outputs();
        check_word("rdata_a_o", rdata_a, exp_rdata_a);
        check_err("err_a_o", err_a, exp_err_a);
        check_word("rdata_b_o", rdata_b, exp_rdata_b);
        check_err("err_b_o", err_b, exp_err_b);
    endtask

    function automatic logic op_from_name(input string name, output mem_op_e op);
        logic found;
        found = 1'b1;
        op    = OP_LW;
        case (name)
            "LB":    op = OP_LB;
            "LH":    op = OP_LH;
            "LW":    op = OP_LW;
            "LBU":   op = OP_LBU;
            "LHU":   op = OP_LHU;
            "SB":    op = OP_SB;
            "SH":    op = OP_SH;
            "SW":    op = OP_SW;
            default: found = 1'b0;
        endcase
        return found;
    endfunction

    task automatic load_vectors();
        int          fd;
        int          n;
        int          line_no;
        int          en_v;
        int          err_v;
        logic [31:0] addr_v;
        logic [31:0] wdata_v;
        logic [31:0] rdata_v;
        logic        op_ok;
        logic        join_v;
        logic        port_ok;
        logic        join_ok;
        byte         letter;
        mem_op_e     op_v;
        string       line;
        string       port_s;
        string       op_s;
        fd = $fopen(VEC_FILE, "r");
        if (fd == 0) begin
            abort_run({"cannot open the vector file ", VEC_FILE});
        end
        line_no = 0;
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            line_no++;
            if (n == 0 || line.len() < 2 || line.getc(0) == "#") begin
                continue;                        // Blank or column notes
            end
            n = $sscanf(line, "%s %d %s %h %h %h %d",
                        port_s, en_v, op_s, addr_v, wdata_v, rdata_v, err_v);
            op_ok   = op_from_name(op_s, op_v);
            join_v  = (port_s.len() == 2) && (port_s.getc(0) == "+");
            letter  = port_s.getc(port_s.len() - 1);
            port_ok = (port_s.len() == 1 || join_v) && (letter == "a" || letter == "b");
            // A joined line pairs with a lone line of the other port
            join_ok = !join_v || (vec_en.size() > 0 && !vec_join[vec_en.size() - 1]
                      && vec_port_b[vec_en.size() - 1] != (letter == "b"));
            if (n != 7 || !op_ok || !port_ok || !join_ok || en_v > 1 || err_v > 1
                || addr_v >= MEM_BYTES) begin
                abort_run($sformatf("malformed vector on line %0d of %s", line_no, VEC_FILE));
            end
            else begin
                vec_port_b.push_back(letter == "b");
                vec_join.push_back(join_v);
                vec_en.push_back(en_v[0]);
                vec_op.push_back(op_v);
                vec_addr.push_back(addr_t'(addr_v));
                vec_wdata.push_back(wdata_v);
                vec_rdata.push_back(rdata_v);
                vec_err.push_back(err_v[0]);
                vec_line.push_back(line_no);
            end
        end
        $fclose(fd);
    endtask

    // Both ports idle, outputs expected back at zero
    task automatic drive_idle();
        en_a        = 1'b0;
        op_a        = OP_LW;
        addr_a      = '0;
        wdata_a     = '0;
        en_b        = 1'b0;
        op_b        = OP_LW;
        addr_b      = '0;
        wdata_b     = '0;
        exp_rdata_a = '0;
        exp_err_a   = 1'b0;
        exp_rdata_b = '0;
        exp_err_b   = 1'b0;
    endtask

    task automatic apply_vector(input int idx);
        if (vec_port_b[idx]) begin
            en_b        = vec_en[idx];
            op_b        = vec_op[idx];
            addr_b      = vec_addr[idx];
            wdata_b     = vec_wdata[idx];
            exp_rdata_b = vec_rdata[idx];
            exp_err_b   = vec_err[idx];
        end
        else begin
            en_a        = vec_en[idx];
            op_a        = vec_op[idx];
            addr_a      = vec_addr[idx];
            wdata_a     = vec_wdata[idx];
            exp_rdata_a = vec_rdata[idx];
            exp_err_a   = vec_err[idx];
        end
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (rst_n_i !== 1'b1) begin
            if (cycles >= RESET_TIMEOUT) begin
                abort_run("reset was never released");
            end
            else begin
                @(negedge clk);
                cycles++;
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial begin : main_seq
        int idx;
        int cycles;
        drive_idle();
        cur_line = 0;
        load_vectors();
        @(negedge clk);
        check_outputs();                         // Reset values, rst_n_i still low
        wait_reset_release();
        @(negedge clk);
        check_outputs();                         // Idle outputs after release
        idx    = 0;
        cycles = 0;
        while (idx < vec_en.size()) begin
            drive_idle();                        // Falling edge, after the last check
            apply_vector(idx);
            cur_line = vec_line[idx];
            idx++;
            if (idx < vec_en.size() && vec_join[idx]) begin
                apply_vector(idx);               // Other port in the same cycle
                idx++;
            end
            @(negedge clk);
            check_outputs();                     // One cycle after the request edge
            cycles++;
        end
        drive_idle();
        if (cycles == 0) begin
            abort_run("the vector file holds no vectors");
        end
        else begin
            $display("All tests passed");
            $finish;
        end
    end

endmodule

//--- dv/mem_test_input.txt
# port en op addr wdata exp_rdata exp_err; addr, wdata and exp_rdata in hex
# port is a or b; +a or +b runs in the same cycle as the line above
a 0 LW  000 00000000 00000000 0
b 0 SW  010 ffffffff 00000000 0
a 1 LW  000 00000000 12345678 0
a 1 LW  004 00000000 deadbeef 0
a 1 LW  008 00000000 01ff7f80 0
a 1 LW  00c 00000000 c4332211 0
b 1 LW  020 00000000 69965aa5 0
a 1 LB  004 00000000 ffffffef 0
a 1 LBU 004 00000000 000000ef 0
a 1 LB  009 00000000 0000007f 0
b 1 LB  008 00000000 ffffff80 0
b 1 LBU 008 00000000 00000080 0
a 1 LH  006 00000000 ffffdead 0
a 1 LHU 006 00000000 0000dead 0
a 1 LH  008 00000000 00007f80 0
b 1 LH  00a 00000000 000001ff 0
b 1 LHU 002 00000000 00001234 0
a 1 SW  010 11223344 00000000 0
a 1 SB  010 000000aa 00000000 0
a 1 LW  010 00000000 112233aa 0
a 1 SB  011 000000bb 00000000 0
a 1 SB  012 0000ffcc 00000000 0
a 1 SB  013 123456dd 00000000 0
a 1 LW  010 00000000 ddccbbaa 0
a 1 SW  014 00000000 00000000 0
a 1 SH  014 0000beef 00000000 0
a 1 SH  016 cafe1234 00000000 0
a 1 LW  014 00000000 1234beef 0
a 1 LH  014 00000000 ffffbeef 0
a 1 LH  016 00000000 00001234 0
a 1 SW  011 ffffffff 00000000 1
a 1 LW  010 00000000 ddccbbaa 0
a 1 SH  015 ffffffff 00000000 1
a 1 LW  014 00000000 1234beef 0
a 1 LW  006 00000000 00000000 1
a 1 LH  003 00000000 00000000 1
a 0 LW  000 00000000 00000000 0
b 1 SW  012 ffffffff 00000000 1
b 1 LHU 011 00000000 00000000 1
b 1 LW  010 00000000 ddccbbaa 0
a 0 SW  010 ffffffff 00000000 0
a 1 LW  010 00000000 ddccbbaa 0
b 1 SW  018 a1b2c3d4 00000000 0
a 1 LW  018 00000000 a1b2c3d4 0
a 1 SW  01c 00000000 00000000 0
a 1 SH  01e 00007788 00000000 0
b 1 LW  01c 00000000 77880000 0
b 1 LBU 01f 00000000 00000077 0
a 1 LW  000 00000000 12345678 0
+b 1 LW  004 00000000 deadbeef 0
a 1 LB  00f 00000000 ffffffc4 0
+b 1 LHU 00e 00000000 0000c433 0
a 1 LW  018 00000000 a1b2c3d4 0
+b 1 SW  018 0badf00d 00000000 0
a 1 LW  018 00000000 0badf00d 0
a 1 SW  024 01020304 00000000 0
+b 1 SW  028 05060708 00000000 0
b 1 LW  024 00000000 01020304 0
+a 1 LW  028 00000000 05060708 0
a 1 LW  002 00000000 00000000 1
+b 1 LH  001 00000000 00000000 1
a 0 LW  000 00000000 00000000 0

//--- dv/mem_image.hex
// Initial RAM bytes, one per line, from address 0
78
56
34
12
ef
be
ad
de
80
7f
ff
01
11
22
33
c4
@020
a5
5a
96
69

//--- files.f
design/rs5_mem_pkg.sv
design/ram_mem.sv
design/lsu_align.sv
design/mem_subsystem.sv
dv/tb_mem_subsystem.sv

//--- Bender.yml
package:
  name: rs5_mem_subsystem

sources:
  # Package first, then leaf modules, then the top level
  - files:
      - design/rs5_mem_pkg.sv
      - design/ram_mem.sv
      - design/lsu_align.sv
      - design/mem_subsystem.sv

  # Simulation only
  - target: test
    files:
      - dv/tb_mem_subsystem.sv
